// ==== compile.f ====
+incdir+rtl
rtl/ahbl_pkg.sv
rtl/ahbl_splitter.sv
rtl/ahbl_arbiter.sv
rtl/ahbl_crossbar.sv
rtl/ahbl_sram.sv
rtl/ahbl_subsystem.sv
test/tb_clk_gen.sv
test/tb_ahbl_subsystem.sv

// ==== Bender.yml ====
package:
  name: ahbl_subsystem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ahbl_pkg.sv
      - rtl/ahbl_splitter.sv
      - rtl/ahbl_arbiter.sv
      - rtl/ahbl_crossbar.sv
      - rtl/ahbl_sram.sv
      - rtl/ahbl_subsystem.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_clk_gen.sv
      - test/tb_ahbl_subsystem.sv

// ==== test/tb_ahbl_subsystem.sv ====
`include "ahbl_cfg.svh"

module tb_ahbl_subsystem;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_M = `AHBL_N_MASTERS;
	localparam int W_A = `AHBL_W_ADDR;
	localparam int W_D = `AHBL_W_DATA;
	localparam int N_ROWS = 9;
	localparam int CLK_PERIOD = 8;

	// One transfer of one master, valid clear means the master sits idle
	typedef struct packed {
		logic valid;
		logic write;
		logic [31:0] addr;
		logic [2:0] size;
		logic [31:0] wdata;
		logic err;
	} xfer_t;

	logic clk;
	logic reset;
	logic [N_M-1:0] src_hready_resp;
	logic [N_M-1:0] src_hresp;
	logic [N_M*W_A-1:0] src_haddr;
	logic [N_M-1:0] src_hwrite;
	logic [N_M*2-1:0] src_htrans;
	logic [N_M*3-1:0] src_hsize;
	logic [N_M*W_D-1:0] src_hwdata;
	logic [N_M*W_D-1:0] src_hrdata;

	xfer_t tbl [N_ROWS][N_M];
	string row_name [N_ROWS];
	logic [31:0] rng;
	logic [7:0] model_mem [logic [31:0]];

	tb_clk_gen #(.PERIOD(CLK_PERIOD)) clk_gen0 (.clk(clk));

	ahbl_subsystem dut0 (
		.clk(clk),
		.reset(reset),
		.src_hready_resp(src_hready_resp),
		.src_hresp(src_hresp),
		.src_haddr(src_haddr),
		.src_hwrite(src_hwrite),
		.src_htrans(src_htrans),
		.src_hsize(src_hsize),
		.src_hwdata(src_hwdata),
		.src_hrdata(src_hrdata)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic put(input int r, input int m, input logic wr, input logic [31:0] addr,
			input logic [2:0] size, input logic err);
		rng = xorshift32(rng);
		tbl[r][m] = '{valid: 1'b1, write: wr, addr: addr, size: size, wdata: rng, err: err};
	endtask

	// ======================================================================
	// Memory model, little endian byte lanes
	// ======================================================================

	function automatic logic [31:0] model_read(input logic [31:0] addr);
		logic [31:0] word;
		logic [31:0] a;
		for (int b = 0; b < 4; b++) begin
			a = {addr[31:2], 2'b00} + b;
			word[b*8 +: 8] = model_mem.exists(a) ? model_mem[a] : 8'hxx;
		end
		return word;
	endfunction

	task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
			input logic [31:0] wdata);
		int n;
		n = 1 << size;
		for (int b = 0; b < 4; b++) begin
			if (b >= addr[1:0] && b < addr[1:0] + n)
				model_mem[{addr[31:2], 2'b00} + b] = wdata[b*8 +: 8];
		end
	endtask

	// Address phase, then data phase, each held until hready_resp is seen high
	task automatic run_xfer(input int m, input xfer_t x, output logic [31:0] rd,
			output logic rs);
		@(posedge clk);
		src_haddr[m*W_A +: W_A] <= x.addr;
		src_hwrite[m] <= x.write;
		src_htrans[m*2 +: 2] <= ahbl_pkg::NONSEQ;
		src_hsize[m*3 +: 3] <= x.size;
		@(negedge clk);
		while (!src_hready_resp[m])
			@(negedge clk);
		@(posedge clk);
		src_htrans[m*2 +: 2] <= ahbl_pkg::IDLE;
		src_hwdata[m*W_D +: W_D] <= x.wdata;
		@(negedge clk);
		while (!src_hready_resp[m])
			@(negedge clk);
		rd = src_hrdata[m*W_D +: W_D];
		rs = src_hresp[m];
		@(posedge clk);
	endtask

	initial begin
		#(N_ROWS * 50 * CLK_PERIOD);
		$display("Timeout: the transfers did not finish within %0d cycles", N_ROWS * 50);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int passes;
		int fails;
		logic ok;
		logic [31:0] exp_rd [N_M];
		logic [31:0] rdata [N_M];
		logic resp [N_M];

		$timeformat(-9, 0, " ns", 0);
		passes = 0;
		fails = 0;
		reset = 1'b1;
		src_haddr = '0;
		src_hwrite = '0;
		src_htrans = '0;
		src_hsize = '0;
		src_hwdata = '0;
		rng = 32'h55ad;

		for (int r = 0; r < N_ROWS; r++) begin
			for (int m = 0; m < N_M; m++)
				tbl[r][m] = '0;
		end
		row_name[0] = "word write";
		put(0, 0, 1'b1, 32'h2000_0010, ahbl_pkg::WORD, 1'b0);
		put(0, 1, 1'b1, 32'h4000_0010, ahbl_pkg::WORD, 1'b0);
		row_name[1] = "word read";
		put(1, 0, 1'b0, 32'h2000_0010, ahbl_pkg::WORD, 1'b0);
		put(1, 1, 1'b0, 32'h4000_0010, ahbl_pkg::WORD, 1'b0);
		row_name[2] = "byte and halfword write";
		put(2, 0, 1'b1, 32'h2000_0011, ahbl_pkg::BYTE, 1'b0);
		put(2, 1, 1'b1, 32'h4000_0012, ahbl_pkg::HALF, 1'b0);
		row_name[3] = "merged word read";
		put(3, 0, 1'b0, 32'h2000_0010, ahbl_pkg::WORD, 1'b0);
		put(3, 1, 1'b0, 32'h4000_0010, ahbl_pkg::WORD, 1'b0);
		// 0x2000_1010 would alias word 4 of slave 0 if it were not rejected
		row_name[4] = "unmapped access";
		put(4, 0, 1'b1, 32'h2000_1010, ahbl_pkg::WORD, 1'b1);
		put(4, 1, 1'b0, 32'h0000_0010, ahbl_pkg::WORD, 1'b1);
		row_name[5] = "window readback";
		put(5, 0, 1'b0, 32'h4000_0010, ahbl_pkg::WORD, 1'b0);
		put(5, 1, 1'b0, 32'h2000_0010, ahbl_pkg::WORD, 1'b0);
		row_name[6] = "contention write";
		put(6, 0, 1'b1, 32'h4000_0100, ahbl_pkg::WORD, 1'b0);
		put(6, 1, 1'b1, 32'h4000_0104, ahbl_pkg::WORD, 1'b0);
		row_name[7] = "contention read";
		put(7, 0, 1'b0, 32'h4000_0104, ahbl_pkg::WORD, 1'b0);
		put(7, 1, 1'b0, 32'h4000_0100, ahbl_pkg::WORD, 1'b0);
		row_name[8] = "parallel read";
		put(8, 0, 1'b0, 32'h2000_0010, ahbl_pkg::WORD, 1'b0);
		put(8, 1, 1'b0, 32'h4000_0104, ahbl_pkg::WORD, 1'b0);

		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// Idle bus right after reset
		@(negedge clk);
		ok = 1'b1;
		assert (src_hready_resp === '1 && src_hresp === '0) else begin
			$display("[ERROR] %0t: after reset hready_resp %b hresp %b, expected 11 and 00",
				$time, src_hready_resp, src_hresp);
			ok = 1'b0;
		end
		$display("Test reset state: %s", ok ? "pass" : "fail");
		if (ok)
			passes++;
		else
			fails++;

		for (int r = 0; r < N_ROWS; r++) begin
			for (int m = 0; m < N_M; m++) begin
				exp_rd[m] = model_read(tbl[r][m].addr);
				rdata[m] = '0;
				resp[m] = 1'b0;
			end
			fork
				if (tbl[r][0].valid) run_xfer(0, tbl[r][0], rdata[0], resp[0]);
				if (tbl[r][1].valid) run_xfer(1, tbl[r][1], rdata[1], resp[1]);
			join
			ok = 1'b1;
			for (int m = 0; m < N_M; m++) begin
				if (tbl[r][m].valid) begin
					assert (resp[m] === tbl[r][m].err) else begin
						$display("[ERROR] %0t: %s master %0d hresp %b, expected %b",
							$time, row_name[r], m, resp[m], tbl[r][m].err);
						ok = 1'b0;
					end
					if (!tbl[r][m].write && !tbl[r][m].err) begin
						assert (rdata[m] === exp_rd[m]) else begin
							$display("[ERROR] %0t: %s master %0d read %h, expected %h",
								$time, row_name[r], m, rdata[m], exp_rd[m]);
							ok = 1'b0;
						end
					end
					if (tbl[r][m].write && !tbl[r][m].err)
						model_write(tbl[r][m].addr, tbl[r][m].size, tbl[r][m].wdata);
				end
			end
			$display("Test %s: %s", row_name[r], ok ? "pass" : "fail");
			if (ok)
				passes++;
			else
				fails++;
		end

		$display("Tests passed %0d, failed %0d", passes, fails);
		if (fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== test/tb_clk_gen.sv ====
module tb_clk_gen #(
	parameter int PERIOD = 8
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

endmodule

// ==== rtl/ahbl_subsystem.sv ====
`include "ahbl_cfg.svh"

module ahbl_subsystem (
	input  logic clk,
	input  logic reset,

	// Master ports
	output logic [`AHBL_N_MASTERS-1:0] src_hready_resp,
	output logic [`AHBL_N_MASTERS-1:0] src_hresp,
	input  logic [`AHBL_N_MASTERS*`AHBL_W_ADDR-1:0] src_haddr,
	input  logic [`AHBL_N_MASTERS-1:0] src_hwrite,
	input  logic [`AHBL_N_MASTERS*2-1:0] src_htrans,
	input  logic [`AHBL_N_MASTERS*3-1:0] src_hsize,
	input  logic [`AHBL_N_MASTERS*`AHBL_W_DATA-1:0] src_hwdata,
	output logic [`AHBL_N_MASTERS*`AHBL_W_DATA-1:0] src_hrdata
);

	localparam int W_A = `AHBL_W_ADDR;
	localparam int W_D = `AHBL_W_DATA;

	wire [`AHBL_N_SLAVES-1:0] dst_hready;
	wire [`AHBL_N_SLAVES-1:0] dst_hready_resp;
	wire [`AHBL_N_SLAVES-1:0] dst_hresp;
	wire [`AHBL_N_SLAVES*W_A-1:0] dst_haddr;
	wire [`AHBL_N_SLAVES-1:0] dst_hwrite;
	wire [`AHBL_N_SLAVES*2-1:0] dst_htrans;
	wire [`AHBL_N_SLAVES*3-1:0] dst_hsize;
	wire [`AHBL_N_SLAVES*W_D-1:0] dst_hwdata;
	wire [`AHBL_N_SLAVES*W_D-1:0] dst_hrdata;

	ahbl_crossbar #(
		.N_MASTERS(`AHBL_N_MASTERS),
		.N_SLAVES(`AHBL_N_SLAVES)
	) xbar (
		.clk(clk),
		.reset(reset),
		.src_hready_resp(src_hready_resp),
		.src_hresp(src_hresp),
		.src_haddr(src_haddr),
		.src_hwrite(src_hwrite),
		.src_htrans(src_htrans),
		.src_hsize(src_hsize),
		.src_hwdata(src_hwdata),
		.src_hrdata(src_hrdata),
		.dst_hready(dst_hready),
		.dst_hready_resp(dst_hready_resp),
		.dst_hresp(dst_hresp),
		.dst_haddr(dst_haddr),
		.dst_hwrite(dst_hwrite),
		.dst_htrans(dst_htrans),
		.dst_hsize(dst_hsize),
		.dst_hwdata(dst_hwdata),
		.dst_hrdata(dst_hrdata)
	);

	// Slave 0 window at 0x2000_0000
	ahbl_sram #(
		.DEPTH(`AHBL_SRAM_DEPTH)
	) sram0 (
		.clk(clk),
		.reset(reset),
		.hready(dst_hready[0]),
		.haddr(dst_haddr[0 +: W_A]),
		.hwrite(dst_hwrite[0]),
		.htrans(ahbl_pkg::htrans_t'(dst_htrans[0 +: 2])),
		.hsize(ahbl_pkg::hsize_t'(dst_hsize[0 +: 3])),
		.hwdata(dst_hwdata[0 +: W_D]),
		.hready_resp(dst_hready_resp[0]),
		.hresp(dst_hresp[0]),
		.hrdata(dst_hrdata[0 +: W_D])
	);

	// Slave 1 window at 0x4000_0000
	ahbl_sram #(
		.DEPTH(`AHBL_SRAM_DEPTH)
	) sram1 (
		.clk(clk),
		.reset(reset),
		.hready(dst_hready[1]),
		.haddr(dst_haddr[W_A +: W_A]),
		.hwrite(dst_hwrite[1]),
		.htrans(ahbl_pkg::htrans_t'(dst_htrans[2 +: 2])),
		.hsize(ahbl_pkg::hsize_t'(dst_hsize[3 +: 3])),
		.hwdata(dst_hwdata[W_D +: W_D]),
		.hready_resp(dst_hready_resp[1]),
		.hresp(dst_hresp[1]),
		.hrdata(dst_hrdata[W_D +: W_D])
	);

endmodule

// ==== rtl/ahbl_sram.sv ====
`include "ahbl_cfg.svh"

module ahbl_sram #(
	parameter int DEPTH = `AHBL_SRAM_DEPTH
) (
	input  logic clk,
	input  logic reset,
	input  logic hready,
	input  logic [`AHBL_W_ADDR-1:0] haddr,
	input  logic hwrite,
	input  ahbl_pkg::htrans_t htrans,
	input  ahbl_pkg::hsize_t hsize,
	input  logic [`AHBL_W_DATA-1:0] hwdata,
	output logic hready_resp,
	output ahbl_pkg::hresp_t hresp,
	output logic [`AHBL_W_DATA-1:0] hrdata
);

	localparam int N_LANES = `AHBL_W_DATA / 8;
	localparam int W_IDX = $clog2(DEPTH);

	logic [`AHBL_W_DATA-1:0] mem [DEPTH];

	logic aph_active;
	logic [N_LANES-1:0] aph_lanes;
	logic dph_write;
	logic [N_LANES-1:0] dph_lanes;
	logic [W_IDX-1:0] dph_idx;

	assign aph_active = hready && (htrans == ahbl_pkg::NONSEQ || htrans == ahbl_pkg::SEQ);

	// Byte lanes from size and the low address bits
	always_comb begin
		case (hsize)
			ahbl_pkg::BYTE: aph_lanes = N_LANES'(1) << haddr[1:0];
			ahbl_pkg::HALF: aph_lanes = N_LANES'(3) << {haddr[1], 1'b0};
			default: aph_lanes = '1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			dph_write <= 1'b0;
		else if (hready)
			dph_write <= aph_active && hwrite;
	end

	always_ff @(posedge clk) begin
		if (aph_active) begin
			dph_idx <= haddr[W_IDX+1:2];
			dph_lanes <= aph_lanes;
		end
		if (dph_write) begin
			for (int b = 0; b < N_LANES; b++) begin
				if (dph_lanes[b])
					mem[dph_idx][b*8 +: 8] <= hwdata[b*8 +: 8];
			end
		end
	end

	// Zero wait states, never an error
	assign hready_resp = 1'b1;
	assign hresp = ahbl_pkg::OKAY;
	assign hrdata = mem[dph_idx];

	a_size_legal: assert property (@(posedge clk) disable iff (reset)
		aph_active |-> hsize <= ahbl_pkg::WORD);

	a_aligned: assert property (@(posedge clk) disable iff (reset)
		aph_active |-> !((hsize == ahbl_pkg::HALF && haddr[0]) ||
			(hsize == ahbl_pkg::WORD && haddr[1:0] != 2'b00)));

endmodule

// ==== rtl/ahbl_crossbar.sv ====
`include "ahbl_cfg.svh"

module ahbl_crossbar #(
	parameter int N_MASTERS = `AHBL_N_MASTERS,
	parameter int N_SLAVES = `AHBL_N_SLAVES
) (
	input  logic clk,
	input  logic reset,

	// Master ports
	output logic [N_MASTERS-1:0] src_hready_resp,
	output logic [N_MASTERS-1:0] src_hresp,
	input  logic [N_MASTERS*`AHBL_W_ADDR-1:0] src_haddr,
	input  logic [N_MASTERS-1:0] src_hwrite,
	input  logic [N_MASTERS*2-1:0] src_htrans,
	input  logic [N_MASTERS*3-1:0] src_hsize,
	input  logic [N_MASTERS*`AHBL_W_DATA-1:0] src_hwdata,
	output logic [N_MASTERS*`AHBL_W_DATA-1:0] src_hrdata,

	// Slave ports
	output logic [N_SLAVES-1:0] dst_hready,
	input  logic [N_SLAVES-1:0] dst_hready_resp,
	input  logic [N_SLAVES-1:0] dst_hresp,
	output logic [N_SLAVES*`AHBL_W_ADDR-1:0] dst_haddr,
	output logic [N_SLAVES-1:0] dst_hwrite,
	output logic [N_SLAVES*2-1:0] dst_htrans,
	output logic [N_SLAVES*3-1:0] dst_hsize,
	output logic [N_SLAVES*`AHBL_W_DATA-1:0] dst_hwdata,
	input  logic [N_SLAVES*`AHBL_W_DATA-1:0] dst_hrdata
);

	localparam int W_A = `AHBL_W_ADDR;
	localparam int W_D = `AHBL_W_DATA;

	// ===================================================================
	// Matrix wires, m_* sliced by slave and s_* sliced by master
	// ===================================================================

	wire [N_SLAVES-1:0] m_hready [N_MASTERS];
	wire [N_SLAVES*W_A-1:0] m_haddr [N_MASTERS];
	wire [N_SLAVES-1:0] m_hwrite [N_MASTERS];
	wire [N_SLAVES*2-1:0] m_htrans [N_MASTERS];
	wire [N_SLAVES*3-1:0] m_hsize [N_MASTERS];
	wire [N_SLAVES*W_D-1:0] m_hwdata [N_MASTERS];
	wire [N_SLAVES-1:0] m_hready_resp [N_MASTERS];
	wire [N_SLAVES-1:0] m_hresp [N_MASTERS];
	wire [N_SLAVES*W_D-1:0] m_hrdata [N_MASTERS];

	wire [N_MASTERS-1:0] s_hready [N_SLAVES];
	wire [N_MASTERS*W_A-1:0] s_haddr [N_SLAVES];
	wire [N_MASTERS-1:0] s_hwrite [N_SLAVES];
	wire [N_MASTERS*2-1:0] s_htrans [N_SLAVES];
	wire [N_MASTERS*3-1:0] s_hsize [N_SLAVES];
	wire [N_MASTERS*W_D-1:0] s_hwdata [N_SLAVES];
	wire [N_MASTERS-1:0] s_hready_resp [N_SLAVES];
	wire [N_MASTERS-1:0] s_hresp [N_SLAVES];
	wire [N_MASTERS*W_D-1:0] s_hrdata [N_SLAVES];

	// Transpose, requests forward and responses back
	for (genvar i = 0; i < N_MASTERS; i++) begin : g_m
		for (genvar j = 0; j < N_SLAVES; j++) begin : g_s
			assign s_hready[j][i] = m_hready[i][j];
			assign s_haddr[j][i*W_A +: W_A] = m_haddr[i][j*W_A +: W_A];
			assign s_hwrite[j][i] = m_hwrite[i][j];
			assign s_htrans[j][i*2 +: 2] = m_htrans[i][j*2 +: 2];
			assign s_hsize[j][i*3 +: 3] = m_hsize[i][j*3 +: 3];
			assign s_hwdata[j][i*W_D +: W_D] = m_hwdata[i][j*W_D +: W_D];
			assign m_hready_resp[i][j] = s_hready_resp[j][i];
			assign m_hresp[i][j] = s_hresp[j][i];
			assign m_hrdata[i][j*W_D +: W_D] = s_hrdata[j][i*W_D +: W_D];
		end
	end

	for (genvar i = 0; i < N_MASTERS; i++) begin : g_split
		ahbl_splitter #(
			.N_PORTS(N_SLAVES)
		) split (
			.clk(clk),
			.reset(reset),
			.src_hready_resp(src_hready_resp[i]),
			.src_hresp(src_hresp[i]),
			.src_haddr(src_haddr[i*W_A +: W_A]),
			.src_hwrite(src_hwrite[i]),
			.src_htrans(ahbl_pkg::htrans_t'(src_htrans[i*2 +: 2])),
			.src_hsize(ahbl_pkg::hsize_t'(src_hsize[i*3 +: 3])),
			.src_hwdata(src_hwdata[i*W_D +: W_D]),
			.src_hrdata(src_hrdata[i*W_D +: W_D]),
			.dst_hready(m_hready[i]),
			.dst_haddr(m_haddr[i]),
			.dst_hwrite(m_hwrite[i]),
			.dst_htrans(m_htrans[i]),
			.dst_hsize(m_hsize[i]),
			.dst_hwdata(m_hwdata[i]),
			.dst_hready_resp(m_hready_resp[i]),
			.dst_hresp(m_hresp[i]),
			.dst_hrdata(m_hrdata[i])
		);
	end

	for (genvar j = 0; j < N_SLAVES; j++) begin : g_arb
		ahbl_arbiter #(
			.N_PORTS(N_MASTERS)
		) arb (
			.clk(clk),
			.reset(reset),
			.src_hready(s_hready[j]),
			.src_haddr(s_haddr[j]),
			.src_hwrite(s_hwrite[j]),
			.src_htrans(s_htrans[j]),
			.src_hsize(s_hsize[j]),
			.src_hwdata(s_hwdata[j]),
			.src_hready_resp(s_hready_resp[j]),
			.src_hresp(s_hresp[j]),
			.src_hrdata(s_hrdata[j]),
			.dst_hready(dst_hready[j]),
			.dst_haddr(dst_haddr[j*W_A +: W_A]),
			.dst_hwrite(dst_hwrite[j]),
			.dst_htrans(dst_htrans[j*2 +: 2]),
			.dst_hsize(dst_hsize[j*3 +: 3]),
			.dst_hwdata(dst_hwdata[j*W_D +: W_D]),
			.dst_hready_resp(dst_hready_resp[j]),
			.dst_hresp(dst_hresp[j]),
			.dst_hrdata(dst_hrdata[j*W_D +: W_D])
		);
	end

endmodule

// ==== rtl/ahbl_arbiter.sv ====
`include "ahbl_cfg.svh"

module ahbl_arbiter #(
	parameter int N_PORTS = `AHBL_N_MASTERS
) (
	input  logic clk,
	input  logic reset,

	// Master side, one slice per port
	input  logic [N_PORTS-1:0] src_hready,
	input  logic [N_PORTS*`AHBL_W_ADDR-1:0] src_haddr,
	input  logic [N_PORTS-1:0] src_hwrite,
	input  logic [N_PORTS*2-1:0] src_htrans,
	input  logic [N_PORTS*3-1:0] src_hsize,
	input  logic [N_PORTS*`AHBL_W_DATA-1:0] src_hwdata,
	output logic [N_PORTS-1:0] src_hready_resp,
	output logic [N_PORTS-1:0] src_hresp,
	output logic [N_PORTS*`AHBL_W_DATA-1:0] src_hrdata,

	// Slave side
	output logic dst_hready,
	output logic [`AHBL_W_ADDR-1:0] dst_haddr,
	output logic dst_hwrite,
	output logic [1:0] dst_htrans,
	output logic [2:0] dst_hsize,
	output logic [`AHBL_W_DATA-1:0] dst_hwdata,
	input  logic dst_hready_resp,
	input  logic dst_hresp,
	input  logic [`AHBL_W_DATA-1:0] dst_hrdata
);

	localparam int W_A = `AHBL_W_ADDR;
	localparam int W_D = `AHBL_W_DATA;

	logic [N_PORTS-1:0] req_live;
	logic [N_PORTS-1:0] req;
	logic [N_PORTS-1:0] grant;
	logic [N_PORTS-1:0] dph_sel;

	// One-entry request buffer per port
	logic [N_PORTS-1:0] buf_valid;
	logic [W_A-1:0] buf_haddr [N_PORTS];
	logic [N_PORTS-1:0] buf_hwrite;
	logic [1:0] buf_htrans [N_PORTS];
	logic [2:0] buf_hsize [N_PORTS];

	// ===================================================================
	// Request and grant
	// ===================================================================

	// htrans bit 1 marks NONSEQ or SEQ
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			req_live[i] = src_hready[i] && src_htrans[i*2+1];
		end
	end

	assign req = req_live | buf_valid;

	// The slave's own ready ends its data phase and opens the next address phase
	assign dst_hready = dst_hready_resp;

	// Lowest set bit wins
	assign grant = dst_hready ? (req & (~req + 1'b1)) : '0;

	always_comb begin
		dst_haddr = '0;
		dst_hwrite = 1'b0;
		dst_htrans = ahbl_pkg::IDLE;
		dst_hsize = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			if (grant[i] && buf_valid[i]) begin
				dst_haddr = buf_haddr[i];
				dst_hwrite = buf_hwrite[i];
				dst_htrans = buf_htrans[i];
				dst_hsize = buf_hsize[i];
			end else if (grant[i]) begin
				dst_haddr = src_haddr[i*W_A +: W_A];
				dst_hwrite = src_hwrite[i];
				dst_htrans = src_htrans[i*2 +: 2];
				dst_hsize = src_hsize[i*3 +: 3];
			end
		end
	end

	// ===================================================================
	// Buffer and data phase owner
	// ===================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			buf_valid <= '0;
			dph_sel <= '0;
		end else begin
			buf_valid <= ~grant & (buf_valid | req_live);
			if (dst_hready)
				dph_sel <= grant;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_PORTS; i++) begin
			if (req_live[i] && !grant[i]) begin
				buf_haddr[i] <= src_haddr[i*W_A +: W_A];
				buf_hwrite[i] <= src_hwrite[i];
				buf_htrans[i] <= src_htrans[i*2 +: 2];
				buf_hsize[i] <= src_hsize[i*3 +: 3];
			end
		end
	end

	// A waiting master is held with hready_resp low until its turn comes
	always_comb begin
		dst_hwdata = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			if (dph_sel[i])
				dst_hwdata = src_hwdata[i*W_D +: W_D];
			src_hready_resp[i] = dph_sel[i] ? dst_hready_resp : !buf_valid[i];
			src_hresp[i] = dph_sel[i] ? dst_hresp : ahbl_pkg::OKAY;
			src_hrdata[i*W_D +: W_D] = dph_sel[i] ? dst_hrdata : '0;
		end
	end

	// The splitter must keep a buffered master stalled
	a_buf_no_overwrite: assert property (@(posedge clk) disable iff (reset)
		(buf_valid & req_live) == '0);

endmodule

// ==== rtl/ahbl_splitter.sv ====
`include "ahbl_cfg.svh"

module ahbl_splitter #(
	parameter int N_PORTS = `AHBL_N_SLAVES,
	parameter logic [N_PORTS*`AHBL_W_ADDR-1:0] ADDR_MAP = `AHBL_ADDR_MAP,
	parameter logic [N_PORTS*`AHBL_W_ADDR-1:0] ADDR_MASK = `AHBL_ADDR_MASK
) (
	input  logic clk,
	input  logic reset,

	// Master side
	output logic src_hready_resp,
	output ahbl_pkg::hresp_t src_hresp,
	input  logic [`AHBL_W_ADDR-1:0] src_haddr,
	input  logic src_hwrite,
	input  ahbl_pkg::htrans_t src_htrans,
	input  ahbl_pkg::hsize_t src_hsize,
	input  logic [`AHBL_W_DATA-1:0] src_hwdata,
	output logic [`AHBL_W_DATA-1:0] src_hrdata,

	// Slave side, one slice per port
	output logic [N_PORTS-1:0] dst_hready,
	output logic [N_PORTS*`AHBL_W_ADDR-1:0] dst_haddr,
	output logic [N_PORTS-1:0] dst_hwrite,
	output logic [N_PORTS*2-1:0] dst_htrans,
	output logic [N_PORTS*3-1:0] dst_hsize,
	output logic [N_PORTS*`AHBL_W_DATA-1:0] dst_hwdata,
	input  logic [N_PORTS-1:0] dst_hready_resp,
	input  logic [N_PORTS-1:0] dst_hresp,
	input  logic [N_PORTS*`AHBL_W_DATA-1:0] dst_hrdata
);

	localparam int W_A = `AHBL_W_ADDR;
	localparam int W_D = `AHBL_W_DATA;

	logic src_active;
	logic [N_PORTS-1:0] aph_sel;
	logic [N_PORTS-1:0] dph_sel;
	logic err_first;
	logic err_second;

	// ===================================================================
	// Address phase decode
	// ===================================================================

	assign src_active = src_htrans == ahbl_pkg::NONSEQ || src_htrans == ahbl_pkg::SEQ;

	always_comb begin
		for (int j = 0; j < N_PORTS; j++) begin
			aph_sel[j] = src_active &&
				((src_haddr & ADDR_MASK[j*W_A +: W_A]) == ADDR_MAP[j*W_A +: W_A]);
		end
	end

	// Everything but htrans is broadcast, so unselected ports just see IDLE
	always_comb begin
		for (int j = 0; j < N_PORTS; j++) begin
			dst_hready[j] = src_hready_resp;
			dst_haddr[j*W_A +: W_A] = src_haddr;
			dst_hwrite[j] = src_hwrite;
			dst_htrans[j*2 +: 2] = aph_sel[j] ? src_htrans : ahbl_pkg::IDLE;
			dst_hsize[j*3 +: 3] = src_hsize;
			dst_hwdata[j*W_D +: W_D] = src_hwdata;
		end
	end

	// ===================================================================
	// Data phase tracking
	// ===================================================================

	// err_first and err_second are the two cycles of the ERROR response
	always_ff @(posedge clk) begin
		if (reset) begin
			dph_sel <= '0;
			err_first <= 1'b0;
			err_second <= 1'b0;
		end else begin
			err_second <= err_first;
			if (src_hready_resp) begin
				dph_sel <= aph_sel;
				err_first <= src_active && ~|aph_sel;
			end else begin
				err_first <= 1'b0;
			end
		end
	end

	always_comb begin
		src_hready_resp = 1'b1;
		src_hresp = ahbl_pkg::OKAY;
		src_hrdata = '0;
		for (int j = 0; j < N_PORTS; j++) begin
			if (dph_sel[j]) begin
				src_hready_resp = dst_hready_resp[j];
				src_hresp = ahbl_pkg::hresp_t'(dst_hresp[j]);
				src_hrdata = dst_hrdata[j*W_D +: W_D];
			end
		end
		if (err_first) begin
			src_hready_resp = 1'b0;
			src_hresp = ahbl_pkg::ERROR;
		end else if (err_second) begin
			src_hresp = ahbl_pkg::ERROR;
		end
	end

	// Overlapping map windows would steer one transfer to two slaves
	a_sel_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(aph_sel));

endmodule

// ==== rtl/ahbl_pkg.sv ====
package ahbl_pkg;

	// Transfer type, bit 1 set marks an active transfer
	typedef enum logic [1:0] {
		IDLE = 2'b00,
		BUSY = 2'b01,
		NONSEQ = 2'b10,
		SEQ = 2'b11
	} htrans_t;

	// Transfer size, only up to the bus width
	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_t;

	typedef enum logic {
		OKAY = 1'b0,
		ERROR = 1'b1
	} hresp_t;

endpackage

// ==== rtl/ahbl_cfg.svh ====
`ifndef AHBL_CFG_SVH
`define AHBL_CFG_SVH

// ===================================================================
// Bus widths and port counts
// ===================================================================

`define AHBL_W_ADDR 32
`define AHBL_W_DATA 32

`define AHBL_N_MASTERS 2
`define AHBL_N_SLAVES 2

// ===================================================================
// Address map, slave 1 in the upper word and slave 0 in the lower
// ===================================================================

`define AHBL_ADDR_MAP 64'h40000000_20000000
`define AHBL_ADDR_MASK 64'hfffff000_fffff000

// Words per SRAM, one 4 KiB window
`define AHBL_SRAM_DEPTH 1024

`endif
